// File: analog_io.f
rtl/analog_io_pkg.sv
rtl/adc_frontend.sv
rtl/linear_cal.sv
rtl/dac_backend.sv
rtl/trigger_debounce.sv
rtl/analog_io_top.sv
testbench/tb_analog_io.sv

// File: run_sim.sh
#!/bin/sh
# compile the RTL and testbench with Verilator, run, then scan the log

verilator --binary --timing -Wno-fatal --top-module tb_analog_io \
  -f analog_io.f -o sim_analog_io \
  && ./obj_dir/sim_analog_io > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "build or simulation run error"; exit 1; }

cat sim.log

grep -q "Regression failed" sim.log \
  && { echo "simulation result: FAIL"; exit 1; } \
  || { echo "simulation result: PASS"; exit 0; }

// File: testbench/tb_analog_io.sv
// analog data path testbench

`default_nettype none

module tb_analog_io import analog_io_pkg::*; ();

  localparam int MODE_ACQ  = 0;
  localparam int MODE_GEN  = 1;
  localparam int MODE_LOOP = 2;
  localparam int N_VEC     = 10;
  // watchdog budget in clock cycles
  localparam int WATCHDOG_CYCLES = N_VEC * 40 + 400;

  typedef struct packed {
    int ch;
    int mode;
    int stim;
    int gain;
    int offset;
    int expected;
  } vec_t;

  logic                                 adc_clk;
  logic                                 top_rst;
  logic    [CHANNELS-1:0][ADC_RAW_W-1:0] adc_dat_i;
  logic    [CHANNELS-1:0]                loop_en_i;
  gain_t   [CHANNELS-1:0]                adc_gain_i;
  offset_t [CHANNELS-1:0]                adc_offset_i;
  gain_t   [CHANNELS-1:0]                dac_gain_i;
  offset_t [CHANNELS-1:0]                dac_offset_i;
  logic    [CHANNELS-1:0]                osc_valid_o;
  sample_t [CHANNELS-1:0]                osc_data_o;
  logic    [CHANNELS-1:0]                osc_ready_i;
  logic    [CHANNELS-1:0]                gen_valid_i;
  sample_t [CHANNELS-1:0]                gen_data_i;
  logic    [CHANNELS-1:0]                gen_ready_o;
  logic    [CHANNELS-1:0][SAMPLE_W-1:0]  dac_dat_o;
  logic                                 gpio_trg_i;
  logic                                 trg_pos_o;
  logic                                 trg_neg_o;

  vec_t tab [N_VEC];
  int   errors;
  int   errors_at_start;
  int   tests_run;
  int   tests_failed;
  // edge pulse counters, written only by the monitor below
  int   pos_cnt;
  int   neg_cnt;

  analog_io_top uut (.*);

  ////////////////////////////////////////////////////////////
  // clock, watchdog, pulse monitor
  ////////////////////////////////////////////////////////////

  initial begin
    adc_clk = 1'b0;
    forever #50 adc_clk = ~adc_clk;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge adc_clk);
    $display("timeout: the run did not finish within %0d clock cycles", WATCHDOG_CYCLES);
    $display("Regression failed");
    $finish;
  end

  // count trigger pulses away from the active edge
  initial begin
    pos_cnt = 0;
    neg_cnt = 0;
    forever begin
      @(negedge adc_clk);
      if (trg_pos_o) pos_cnt++;
      if (trg_neg_o) neg_cnt++;
    end
  end

  ////////////////////////////////////////////////////////////
  // reference model
  ////////////////////////////////////////////////////////////

  // low two bits reserved, sign kept, magnitude inverted
  function automatic int raw_to_sample(input logic [15:0] raw);
    int mag;
    mag = int'(raw[14:2]);
    // inverted magnitude counts inward from either end of the range
    if (raw[15]) begin
      return -1 - mag;
    end
    return 8191 - mag;
  endfunction

  // gain in 3.13 fixed point, then offset, then clamp
  function automatic int calibrate(input int smp, input int gain, input int offset);
    longint prod;
    longint res;
    prod = longint'(smp) * longint'(gain);
    res  = (prod >>> 13) + longint'(offset);
    if (res > 8191) res = 8191;
    else if (res < -8192) res = -8192;
    return int'(res);
  endfunction

  // inverted slope offset binary, full scale positive gives code zero
  function automatic int dac_word(input int smp);
    return 8191 - smp;
  endfunction

  task automatic set_vec(input int idx, input int ch, input int mode,
                         input int stim, input int gain, input int offset);
    tab[idx].ch     = ch;
    tab[idx].mode   = mode;
    tab[idx].stim   = stim;
    tab[idx].gain   = gain;
    tab[idx].offset = offset;
    if (mode == MODE_ACQ) tab[idx].expected = calibrate(raw_to_sample(stim[15:0]), gain, offset);
    else if (mode == MODE_GEN) tab[idx].expected = dac_word(calibrate(stim, gain, offset));
    else tab[idx].expected = calibrate(calibrate(stim, gain, offset), gain, offset);
  endtask

  ////////////////////////////////////////////////////////////
  // reporting
  ////////////////////////////////////////////////////////////

  task automatic report_mismatch(input string what, input int got, input int exp);
    $display("CHECK FAILED at time %0t: %s, got %0d, expected %0d", $time, what, got, exp);
    errors++;
  endtask

  task automatic start_test();
    errors_at_start = errors;
    tests_run++;
  endtask

  task automatic finish_test(input string name);
    if (errors != errors_at_start) begin
      tests_failed++;
      $display("test %s: failed", name);
    end else begin
      $display("test %s: ok", name);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // directed vectors
  ////////////////////////////////////////////////////////////

  task automatic apply_vector(input vec_t v);
    int got;
    @(posedge adc_clk);
    adc_gain_i[v.ch]   <= gain_t'(v.gain);
    adc_offset_i[v.ch] <= offset_t'(v.offset);
    dac_gain_i[v.ch]   <= gain_t'(v.gain);
    dac_offset_i[v.ch] <= offset_t'(v.offset);
    if (v.mode == MODE_ACQ) begin
      adc_dat_i[v.ch] <= ADC_RAW_W'(v.stim);
      // register in front end, then in calibration
      repeat (2) @(posedge adc_clk);
      @(negedge adc_clk);
      got = int'($signed(osc_data_o[v.ch]));
      if (!osc_valid_o[v.ch]) report_mismatch("osc_valid_o", 0, 1);
      if (got != v.expected) report_mismatch("osc_data_o after ADC sample", got, v.expected);
    end else begin
      gen_data_i[v.ch]  <= sample_t'(v.stim);
      gen_valid_i[v.ch] <= 1'b1;
      loop_en_i[v.ch]   <= (v.mode == MODE_LOOP);
      @(negedge adc_clk);
      if (!gen_ready_o[v.ch]) report_mismatch("gen_ready_o", 0, 1);
      // transfer on this edge
      @(posedge adc_clk);
      gen_valid_i[v.ch] <= 1'b0;
      // other data without valid must not reach the DAC
      gen_data_i[v.ch]  <= ~sample_t'(v.stim);
      if (v.mode == MODE_GEN) begin
        @(posedge adc_clk);
        @(negedge adc_clk);
        got = int'(dac_dat_o[v.ch]);
        if (got != v.expected) report_mismatch("dac_dat_o after gen transfer", got, v.expected);
        repeat (3) @(negedge adc_clk);
        got = int'(dac_dat_o[v.ch]);
        if (got != v.expected) begin
          report_mismatch("dac_dat_o hold without gen_valid_i", got, v.expected);
        end
      end else begin
        // DAC cal, loop latch, ADC cal, plus one cycle margin
        repeat (3) @(posedge adc_clk);
        @(negedge adc_clk);
        got = int'($signed(osc_data_o[v.ch]));
        if (got != v.expected) report_mismatch("osc_data_o in loopback", got, v.expected);
        @(posedge adc_clk);
        loop_en_i[v.ch] <= 1'b0;
      end
    end
  endtask

  ////////////////////////////////////////////////////////////
  // back-pressure and trigger
  ////////////////////////////////////////////////////////////

  task automatic run_backpressure();
    int  exp_q[$];
    int  hits[$];
    int  got;
    int  prev_data;
    bit  prev_stall;
    int  transfers;
    logic [15:0] raw;
    prev_stall = 1'b0;
    prev_data  = 0;
    transfers  = 0;
    @(posedge adc_clk);
    adc_gain_i[0]   <= gain_t'(6000);
    adc_offset_i[0] <= offset_t'(100);
    osc_ready_i[0]  <= 1'b1;
    // sample already in the front end register
    exp_q.push_back(calibrate(raw_to_sample(adc_dat_i[0]), 6000, 100));
    for (int i = 0; i < 48; i++) begin
      @(posedge adc_clk);
      raw = 16'($urandom);
      adc_dat_i[0]   <= raw;
      osc_ready_i[0] <= 1'($urandom);
      exp_q.push_back(calibrate(raw_to_sample(raw), 6000, 100));
      @(negedge adc_clk);
      got = int'($signed(osc_data_o[0]));
      if (prev_stall && !osc_valid_o[0]) report_mismatch("osc_valid_o under stall", 0, 1);
      if (prev_stall && got != prev_data) report_mismatch("osc_data_o under stall", got, prev_data);
      if (osc_valid_o[0] && osc_ready_i[0]) begin
        transfers++;
        hits = exp_q.find_index(x) with (x == got);
        if (hits.size() == 0) begin
          $display("error at time %0t: transferred value %0d matches no ADC sample", $time, got);
          errors++;
        end
      end
      prev_stall = osc_valid_o[0] && !osc_ready_i[0];
      prev_data  = got;
    end
    if (transfers == 0) begin
      $display("error: no transfer happened during the back-pressure test");
      errors++;
    end
    @(posedge adc_clk);
    osc_ready_i[0] <= 1'b1;
  endtask

  task automatic run_trigger();
    @(posedge adc_clk);
    gpio_trg_i <= 1'b1;
    repeat (DEBOUNCE_CYCLES + 8) @(posedge adc_clk);
    gpio_trg_i <= 1'b0;
    repeat (DEBOUNCE_CYCLES + 8) @(posedge adc_clk);
    if (pos_cnt != 1) report_mismatch("trg_pos_o pulses, clean edges", pos_cnt, 1);
    if (neg_cnt != 1) report_mismatch("trg_neg_o pulses, clean edges", neg_cnt, 1);
    // rise, then a short low glitch inside the lockout
    gpio_trg_i <= 1'b1;
    repeat (5) @(posedge adc_clk);
    gpio_trg_i <= 1'b0;
    repeat (3) @(posedge adc_clk);
    gpio_trg_i <= 1'b1;
    repeat (DEBOUNCE_CYCLES + 8) @(posedge adc_clk);
    gpio_trg_i <= 1'b0;
    repeat (DEBOUNCE_CYCLES + 8) @(posedge adc_clk);
    @(negedge adc_clk);
    if (pos_cnt != 2) report_mismatch("trg_pos_o pulses with glitch", pos_cnt, 2);
    if (neg_cnt != 2) report_mismatch("trg_neg_o pulses with glitch", neg_cnt, 2);
  endtask

  ////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    void'($urandom(32'h8ef5));
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    top_rst      <= 1'b1;
    adc_dat_i    <= '0;
    loop_en_i    <= '0;
    adc_gain_i   <= {CHANNELS{gain_t'(8192)}};
    adc_offset_i <= '0;
    dac_gain_i   <= {CHANNELS{gain_t'(8192)}};
    dac_offset_i <= '0;
    osc_ready_i  <= '1;
    gen_valid_i  <= '0;
    gen_data_i   <= '0;
    gpio_trg_i   <= 1'b0;
    // acquisition, then saturation corners
    set_vec(0, 0, MODE_ACQ, 16'h1234, 8192, 0);
    set_vec(1, 1, MODE_ACQ, 16'hc004, 12000, -300);
    set_vec(2, 0, MODE_ACQ, int'(16'($urandom)), 8192, 0);
    set_vec(3, 1, MODE_ACQ, 16'h0000, 32767, 8000);
    set_vec(4, 0, MODE_ACQ, 16'hfffc, 32767, -8000);
    // generation, two of them clamp
    set_vec(5, 0, MODE_GEN, 1000, 9000, 50);
    set_vec(6, 1, MODE_GEN, -8000, -20000, 4000);
    set_vec(7, 1, MODE_GEN, 7000, -30000, -8192);
    set_vec(8, 0, MODE_LOOP, -1234, 7000, 20);
    set_vec(9, 1, MODE_LOOP, $urandom_range(0, 16383) - 8192, 8192, -100);

    start_test();
    repeat (15) @(posedge adc_clk);
    @(negedge adc_clk);
    if (osc_valid_o != '0) report_mismatch("osc_valid_o in reset", int'(osc_valid_o), 0);
    if (gen_ready_o != '1) report_mismatch("gen_ready_o in reset", int'(gen_ready_o), 3);
    for (int c = 0; c < CHANNELS; c++) begin
      if (dac_dat_o[c] != 14'h1fff) report_mismatch("dac_dat_o in reset", int'(dac_dat_o[c]), 8191);
    end
    @(posedge adc_clk);
    top_rst <= 1'b0;
    finish_test("reset values");

    for (int i = 0; i < N_VEC; i++) begin
      start_test();
      apply_vector(tab[i]);
      finish_test($sformatf("vector %0d", i));
    end
    start_test();
    run_backpressure();
    finish_test("back-pressure");
    start_test();
    run_trigger();
    finish_test("trigger debounce");

    $display("summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule : tb_analog_io

`default_nettype wire

// File: rtl/analog_io_top.sv
// analog data path top level

`default_nettype none

module analog_io_top import analog_io_pkg::*; (
  input  wire logic                                  adc_clk,
  input  wire logic                                  top_rst,
  // ADC pins
  input  wire logic    [CHANNELS-1:0][ADC_RAW_W-1:0] adc_dat_i,
  // digital loopback enable per channel
  input  wire logic    [CHANNELS-1:0]                loop_en_i,
  // acquisition calibration
  input  wire gain_t   [CHANNELS-1:0]                adc_gain_i,
  input  wire offset_t [CHANNELS-1:0]                adc_offset_i,
  // generation calibration
  input  wire gain_t   [CHANNELS-1:0]                dac_gain_i,
  input  wire offset_t [CHANNELS-1:0]                dac_offset_i,
  // acquisition stream out
  output logic         [CHANNELS-1:0]                osc_valid_o,
  output sample_t      [CHANNELS-1:0]                osc_data_o,
  input  wire logic    [CHANNELS-1:0]                osc_ready_i,
  // generation stream in
  input  wire logic    [CHANNELS-1:0]                gen_valid_i,
  input  wire sample_t [CHANNELS-1:0]                gen_data_i,
  output logic         [CHANNELS-1:0]                gen_ready_o,
  // DAC pins
  output logic         [CHANNELS-1:0][SAMPLE_W-1:0]  dac_dat_o,
  // GPIO trigger
  input  wire logic                                  gpio_trg_i,
  output logic                                       trg_pos_o,
  output logic                                       trg_neg_o
);

  ////////////////////////////////////////////////////////////
  // per channel data paths
  ////////////////////////////////////////////////////////////

  for (genvar ch = 0; ch < CHANNELS; ch++) begin : g_chan

    // front end to ADC calibration
    logic    adc_valid;
    sample_t adc_data;
    // DAC calibration to backend and loopback
    logic    dac_valid;
    sample_t dac_data;

    // register, convert, pick ADC or loopback
    adc_frontend u_frontend (
      .adc_clk      (adc_clk),
      .top_rst      (top_rst),
      .adc_raw_i    (adc_dat_i[ch]),
      .loop_en_i    (loop_en_i[ch]),
      .loop_valid_i (dac_valid),
      .loop_data_i  (dac_data),
      .valid_o      (adc_valid),
      .data_o       (adc_data)
    );

    // acquisition calibration
    // ready is not used, a stalled ADC sample is simply lost
    linear_cal u_cal_adc (
      .adc_clk  (adc_clk),
      .top_rst  (top_rst),
      .gain_i   (adc_gain_i[ch]),
      .offset_i (adc_offset_i[ch]),
      .valid_i  (adc_valid),
      .data_i   (adc_data),
      .ready_o  (),
      .valid_o  (osc_valid_o[ch]),
      .data_o   (osc_data_o[ch]),
      .ready_i  (osc_ready_i[ch])
    );

    // generation calibration, DAC side never stalls
    linear_cal u_cal_dac (
      .adc_clk  (adc_clk),
      .top_rst  (top_rst),
      .gain_i   (dac_gain_i[ch]),
      .offset_i (dac_offset_i[ch]),
      .valid_i  (gen_valid_i[ch]),
      .data_i   (gen_data_i[ch]),
      .ready_o  (gen_ready_o[ch]),
      .valid_o  (dac_valid),
      .data_o   (dac_data),
      .ready_i  (1'b1)
    );

    // offset binary output register
    dac_backend u_dac (
      .adc_clk   (adc_clk),
      .top_rst   (top_rst),
      .valid_i   (dac_valid),
      .data_i    (dac_data),
      .dac_dat_o (dac_dat_o[ch])
    );

  end : g_chan

  ////////////////////////////////////////////////////////////
  // trigger input
  ////////////////////////////////////////////////////////////

  trigger_debounce u_trg (
    .adc_clk   (adc_clk),
    .top_rst   (top_rst),
    .trg_i     (gpio_trg_i),
    .trg_pos_o (trg_pos_o),
    .trg_neg_o (trg_neg_o)
  );

endmodule : analog_io_top

`default_nettype wire

// File: rtl/trigger_debounce.sv
// GPIO trigger debouncer

`default_nettype none

module trigger_debounce import analog_io_pkg::*; (
  input  wire logic adc_clk,
  input  wire logic top_rst,
  // asynchronous trigger pin
  input  wire logic trg_i,
  // one cycle edge pulses
  output logic      trg_pos_o,
  output logic      trg_neg_o
);

  ////////////////////////////////////////////////////////////
  // synchronizer
  ////////////////////////////////////////////////////////////

  // two flops, bit 1 is the safe one
  logic [1:0] sync_q;

  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      sync_q <= 2'b00;
    end else begin
      sync_q <= {sync_q[0], trg_i};
    end
  end

  ////////////////////////////////////////////////////////////
  // stable level and lockout
  ////////////////////////////////////////////////////////////

  // accepted level
  logic                  state_q;
  // lockout counter, zero when idle
  logic [DEBOUNCE_W-1:0] cnt_q;
  // registered pulses
  logic                  pos_q;
  logic                  neg_q;
  // new level seen outside the lockout
  logic                  accept;

  assign accept = (sync_q[1] != state_q) && (cnt_q == '0);

  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      state_q <= 1'b0;
      cnt_q   <= '0;
      pos_q   <= 1'b0;
      neg_q   <= 1'b0;
    end else if (accept) begin
      // take the new level and start the lockout
      state_q <= sync_q[1];
      cnt_q   <= DEBOUNCE_W'(DEBOUNCE_CYCLES);
      pos_q   <= sync_q[1];
      neg_q   <= ~sync_q[1];
    end else begin
      // changes during lockout are ignored
      if (cnt_q != '0) begin
        cnt_q <= cnt_q - 1'b1;
      end
      pos_q <= 1'b0;
      neg_q <= 1'b0;
    end
  end

  assign trg_pos_o = pos_q;
  assign trg_neg_o = neg_q;

endmodule : trigger_debounce

`default_nettype wire

// File: rtl/dac_backend.sv
// DAC output formatting

`default_nettype none

module dac_backend import analog_io_pkg::*; (
  input  wire logic                adc_clk,
  input  wire logic                top_rst,
  // stream from calibration, always accepted
  input  wire logic                valid_i,
  input  wire sample_t             data_i,
  // DAC word
  output logic      [SAMPLE_W-1:0] dac_dat_o
);

  ////////////////////////////////////////////////////////////
  // code conversion
  ////////////////////////////////////////////////////////////

  // signed to offset binary with negative slope
  // sign bit stays, magnitude bits flip
  logic [SAMPLE_W-1:0] dac_code;

  assign dac_code = {data_i[SAMPLE_W-1], ~data_i[SAMPLE_W-2:0]};

  ////////////////////////////////////////////////////////////
  // output register
  ////////////////////////////////////////////////////////////

  logic [SAMPLE_W-1:0] dac_q;

  // mid scale after reset
  // otherwise load on each valid sample and hold in between
  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      dac_q <= DAC_ZERO;
    end else if (valid_i) begin
      dac_q <= dac_code;
    end
  end

  // straight from the register to the pins
  assign dac_dat_o = dac_q;

endmodule : dac_backend

`default_nettype wire

// File: rtl/linear_cal.sv
// linear gain and offset calibration

`default_nettype none

module linear_cal import analog_io_pkg::*; (
  input  wire logic    adc_clk,
  input  wire logic    top_rst,
  // calibration settings, quasi static
  input  wire gain_t   gain_i,
  input  wire offset_t offset_i,
  // input stream
  input  wire logic    valid_i,
  input  wire sample_t data_i,
  output logic         ready_o,
  // output stream
  output logic         valid_o,
  output sample_t      data_o,
  input  wire logic    ready_i
);

  ////////////////////////////////////////////////////////////
  // arithmetic
  ////////////////////////////////////////////////////////////

  // full precision product
  logic signed [CAL_PROD_W-1:0] prod;
  // product scaled back to sample units
  logic signed [CAL_PROD_W-1:0] scaled;
  // scaled product plus offset
  logic signed [CAL_SUM_W-1:0]  sum;
  // saturated result
  sample_t                      clamped;

  // both operands signed, so the multiply is signed
  assign prod   = data_i * gain_i;
  // drop fraction bits, keep sign
  assign scaled = prod >>> GAIN_FRAC;

  // top bits of scaled are sign copies only
  assign sum = $signed(scaled[CAL_SUM_W-1:0]) + offset_i;

  // clamp to the sample range
  always_comb begin
    if (sum > SAMPLE_MAX) begin
      clamped = SAMPLE_MAX;
    end else if (sum < SAMPLE_MIN) begin
      clamped = SAMPLE_MIN;
    end else begin
      clamped = sum[SAMPLE_W-1:0];
    end
  end

  ////////////////////////////////////////////////////////////
  // output register stage
  ////////////////////////////////////////////////////////////

  logic    valid_q;
  sample_t data_q;

  // stage can take a new sample when empty or draining
  assign ready_o = ~valid_q | ready_i;

  // valid follows the input whenever the stage moves
  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      valid_q <= 1'b0;
    end else if (ready_o) begin
      valid_q <= valid_i;
    end
  end

  // payload loads only on an accepted sample
  // held under back pressure
  always_ff @(posedge adc_clk) begin
    if (valid_i && ready_o) begin
      data_q <= clamped;
    end
  end

  assign valid_o = valid_q;
  assign data_o  = data_q;

endmodule : linear_cal

`default_nettype wire

// File: rtl/adc_frontend.sv
// ADC front end with loopback

`default_nettype none

module adc_frontend import analog_io_pkg::*; (
  input  wire logic                 adc_clk,
  input  wire logic                 top_rst,
  // raw ADC word
  input  wire logic [ADC_RAW_W-1:0] adc_raw_i,
  // loopback control and source
  input  wire logic                 loop_en_i,
  input  wire logic                 loop_valid_i,
  input  wire sample_t              loop_data_i,
  // stream toward calibration
  output logic                      valid_o,
  output sample_t                   data_o
);

  ////////////////////////////////////////////////////////////
  // raw conversion
  ////////////////////////////////////////////////////////////

  // registered ADC sample
  sample_t adc_sample_q;
  // last DAC path sample
  sample_t loop_sample_q;
  // stream valid, high from the first cycle after reset
  logic    valid_q;

  // drop reserved low bits, keep sign, invert magnitude
  always_ff @(posedge adc_clk) begin
    adc_sample_q <= {adc_raw_i[ADC_RAW_W-1],
                     ~adc_raw_i[ADC_RAW_W-2:ADC_RAW_W-SAMPLE_W]};
  end

  ////////////////////////////////////////////////////////////
  // loopback
  ////////////////////////////////////////////////////////////

  // DAC side is always ready, so every valid sample counts
  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      loop_sample_q <= '0;
    end else if (loop_valid_i) begin
      loop_sample_q <= loop_data_i;
    end
  end

  // ADC never stalls
  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= 1'b1;
    end
  end

  // output select
  assign valid_o = valid_q;
  assign data_o  = loop_en_i ? loop_sample_q : adc_sample_q;

endmodule : adc_frontend

`default_nettype wire

// File: rtl/analog_io_pkg.sv
// analog data path definitions

`default_nettype none

package analog_io_pkg;

  ////////////////////////////////////////////////////////////
  // channel count and widths
  ////////////////////////////////////////////////////////////

  // two analog channels, each with one ADC and one DAC
  localparam int unsigned CHANNELS  = 2;
  // raw ADC word, bits 1..0 reserved
  localparam int unsigned ADC_RAW_W = 16;
  // sample width on both paths
  localparam int unsigned SAMPLE_W  = 14;

  ////////////////////////////////////////////////////////////
  // calibration format
  ////////////////////////////////////////////////////////////

  // gain is signed fixed point, 8192 is unity
  localparam int unsigned GAIN_W     = 16;
  localparam int unsigned GAIN_FRAC  = 13;
  // full product width
  localparam int unsigned CAL_PROD_W = SAMPLE_W + GAIN_W;
  // scaled product plus offset, one guard bit for the add
  localparam int unsigned CAL_SUM_W  = CAL_PROD_W - GAIN_FRAC + 1;

  typedef logic signed [SAMPLE_W-1:0] sample_t;
  typedef logic signed [GAIN_W-1:0]   gain_t;
  typedef logic signed [SAMPLE_W-1:0] offset_t;

  // saturation limits
  localparam sample_t SAMPLE_MAX = sample_t'(8191);
  localparam sample_t SAMPLE_MIN = sample_t'(-8192);

  // DAC code for a zero sample, inverted offset binary
  localparam logic [SAMPLE_W-1:0] DAC_ZERO = {1'b0, {(SAMPLE_W-1){1'b1}}};

  ////////////////////////////////////////////////////////////
  // trigger debounce
  ////////////////////////////////////////////////////////////

  // lockout after an accepted edge, short for simulation
  localparam int unsigned DEBOUNCE_CYCLES = 16;
  localparam int unsigned DEBOUNCE_W      = $clog2(DEBOUNCE_CYCLES + 1);

endpackage : analog_io_pkg

`default_nettype wire
